//--- all.f
source/ex_isa_pkg.sv
source/ex_fu_pkg.sv
source/alu.sv
source/branch_unit.sv
source/csr_buffer.sv
source/mult.sv
source/ex_stage.sv
sim/ex_stage_assert.sv
sim/tb_ex_stage.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_ex_stage
RTL_TOP    := ex_stage
FLIST      := all.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_ex_stage.sv
/*
 * Testbench for the execute stage. Drives random ALU, branch, CSR and
 * multiply traffic on the falling edge and checks against a model
 */

`timescale 1ns/10ps

module tb_ex_stage;

    localparam int unsigned NumMultStages = 2;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       flush_i;
    ex_fu_pkg::fu_data_t        fu_data;
    ex_isa_pkg::xlen_t          pc;
    logic                       is_compressed;
    logic                       alu_valid;
    logic                       branch_valid;
    logic                       csr_valid;
    logic                       mult_valid;
    ex_fu_pkg::branch_predict_t branch_predict;
    logic                       csr_commit;
    ex_isa_pkg::xlen_t          flu_result;
    ex_isa_pkg::trans_id_t      flu_trans_id;
    logic                       flu_valid;
    logic                       flu_ready;
    ex_fu_pkg::bp_resolve_t     resolved_branch;
    logic                       resolve_branch;
    ex_isa_pkg::csr_addr_t      csr_addr;
    integer                     seed;

    ex_stage #(
        .NumMultStages (NumMultStages)
    ) u_ex_stage (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .fu_data_i             (fu_data),
        .pc_i                  (pc),
        .is_compressed_instr_i (is_compressed),
        .alu_valid_i           (alu_valid),
        .branch_valid_i        (branch_valid),
        .csr_valid_i           (csr_valid),
        .mult_valid_i          (mult_valid),
        .branch_predict_i      (branch_predict),
        .csr_commit_i          (csr_commit),
        .flu_result_o          (flu_result),
        .flu_trans_id_o        (flu_trans_id),
        .flu_valid_o           (flu_valid),
        .flu_ready_o           (flu_ready),
        .resolved_branch_o     (resolved_branch),
        .resolve_branch_o      (resolve_branch),
        .csr_addr_o            (csr_addr)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_xlen(input string name, input ex_isa_pkg::xlen_t exp,
                              input ex_isa_pkg::xlen_t act);
        if (act !== exp) begin
            report_failure($sformatf("Error: time %0t, %s expected %h, actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_trans_id(input string name, input ex_isa_pkg::trans_id_t exp,
                                  input ex_isa_pkg::trans_id_t act);
        if (act !== exp) begin
            report_failure($sformatf("Error: time %0t, %s expected %h, actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_csr_addr(input string name, input ex_isa_pkg::csr_addr_t exp,
                                  input ex_isa_pkg::csr_addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("Error: time %0t, %s expected %h, actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_resolve(input string name, input ex_fu_pkg::bp_resolve_t exp,
                                 input ex_fu_pkg::bp_resolve_t act);
        if (act !== exp) begin
            report_failure($sformatf("Error: time %0t, %s expected %h, actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("Error: time %0t, %s expected %b, actual %b",
                                     $time, name, exp, act));
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic ex_isa_pkg::xlen_t alu_model(input ex_fu_pkg::fu_data_t d);
        ex_isa_pkg::xlen_t a;
        ex_isa_pkg::xlen_t b;
        a = d.operand_a;
        b = d.operand_b;
        case (d.operation)
            ex_isa_pkg::ADD:  return a + b;
            ex_isa_pkg::SUB:  return a - b;
            ex_isa_pkg::XORL: return a ^ b;
            ex_isa_pkg::ORL:  return a | b;
            ex_isa_pkg::ANDL: return a & b;
            ex_isa_pkg::SLL:  return a << b[4:0];
            ex_isa_pkg::SRL:  return a >> b[4:0];
            ex_isa_pkg::SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ex_isa_pkg::SLTS: return {31'b0, $signed(a) < $signed(b)};
            ex_isa_pkg::SLTU: return {31'b0, a < b};
            default:          return '0;
        endcase
    endfunction

    function automatic logic branch_cond(input ex_fu_pkg::fu_data_t d);
        case (d.operation)
            ex_isa_pkg::EQ:  return d.operand_a == d.operand_b;
            ex_isa_pkg::NE:  return d.operand_a != d.operand_b;
            ex_isa_pkg::LTS: return $signed(d.operand_a) < $signed(d.operand_b);
            ex_isa_pkg::GES: return $signed(d.operand_a) >= $signed(d.operand_b);
            ex_isa_pkg::LTU: return d.operand_a < d.operand_b;
            ex_isa_pkg::GEU: return d.operand_a >= d.operand_b;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic ex_isa_pkg::xlen_t link_model(input ex_isa_pkg::xlen_t pc_v,
                                                     input logic compressed);
        return pc_v + (compressed ? 32'd2 : 32'd4);
    endfunction

    // Non-branch with a taken prediction falls through as a mis-predict
    function automatic ex_fu_pkg::bp_resolve_t branch_model(
        input ex_fu_pkg::fu_data_t d, input ex_isa_pkg::xlen_t pc_v, input logic compressed,
        input ex_fu_pkg::branch_predict_t p, input logic is_branch);
        ex_fu_pkg::bp_resolve_t r;
        r                = '0;
        r.valid          = 1'b1;
        r.pc             = pc_v;
        r.target_address = link_model(pc_v, compressed);
        if (!is_branch) begin
            r.is_mispredict = 1'b1;
            return r;
        end
        if (d.operation == ex_isa_pkg::JALR) begin
            r.is_taken       = 1'b1;
            r.target_address = (d.operand_a + d.imm) & ~32'h1;
        end else if (branch_cond(d)) begin
            r.is_taken       = 1'b1;
            r.target_address = pc_v + d.imm;
        end
        r.is_mispredict = (p.predict_taken != r.is_taken) ||
                          (r.is_taken && (p.predict_address != r.target_address));
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    task automatic drive_idle();
        alu_valid      = 1'b0;
        branch_valid   = 1'b0;
        csr_valid      = 1'b0;
        mult_valid     = 1'b0;
        flush_i        = 1'b0;
        csr_commit     = 1'b0;
        branch_predict = '0;
    endtask

    // Random instruction with an operation from base .. base+count-1
    task automatic load_random(input int base, input int count);
        fu_data.operation = ex_isa_pkg::fu_op_e'(5'(base + ({$random(seed)} % count)));
        fu_data.operand_a = $random(seed);
        fu_data.operand_b = $random(seed);
        fu_data.imm       = $random(seed);
        fu_data.trans_id  = 3'($random(seed));
        pc                = $random(seed) & ~32'h1;
        is_compressed     = 1'($random(seed));
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        #1;
        while (flu_ready !== 1'b1) begin
            if (n >= limit) begin
                report_failure("Timeout: flu_ready_o did not return high after CSR commit");
            end
            @(negedge clk_i);
            #1;
            n++;
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------
    task automatic issue_alu_ops(input int count, input logic predict);
        ex_fu_pkg::bp_resolve_t exp_res;
        repeat (count) begin
            @(negedge clk_i);
            drive_idle();
            load_random(ex_isa_pkg::ADD, 10);
            branch_predict.predict_taken   = predict;
            branch_predict.predict_address = $random(seed);
            alu_valid = 1'b1;
            #1;
            check_bit("flu_valid_o", 1'b1, flu_valid);
            check_xlen("flu_result_o", alu_model(fu_data), flu_result);
            check_trans_id("flu_trans_id_o", fu_data.trans_id, flu_trans_id);
            check_bit("resolve_branch_o", predict, resolve_branch);
            if (predict) begin
                exp_res = branch_model(fu_data, pc, is_compressed, branch_predict, 1'b0);
                check_resolve("resolved_branch_o", exp_res, resolved_branch);
            end
        end
    endtask

    task automatic resolve_branches(input int count);
        ex_fu_pkg::bp_resolve_t exp_res;
        repeat (count) begin
            @(negedge clk_i);
            drive_idle();
            load_random(ex_isa_pkg::EQ, 7);
            // Equal operands now and then so EQ and GE paths get taken
            if ({$random(seed)} % 3 == 0) begin
                fu_data.operand_b = fu_data.operand_a;
            end
            exp_res = branch_model(fu_data, pc, is_compressed, '0, 1'b1);
            branch_predict.predict_taken   = 1'($random(seed));
            branch_predict.predict_address = ({$random(seed)} % 2 == 0) ?
                                             exp_res.target_address : $random(seed);
            exp_res = branch_model(fu_data, pc, is_compressed, branch_predict, 1'b1);
            branch_valid = 1'b1;
            #1;
            check_bit("flu_valid_o", 1'b1, flu_valid);
            check_bit("resolve_branch_o", 1'b1, resolve_branch);
            check_resolve("resolved_branch_o", exp_res, resolved_branch);
            check_xlen("flu_result_o", link_model(pc, is_compressed), flu_result);
            check_trans_id("flu_trans_id_o", fu_data.trans_id, flu_trans_id);
        end
    endtask

    task automatic hold_csr(input int count);
        ex_fu_pkg::fu_data_t issued;
        int                  hold;
        repeat (count) begin
            @(negedge clk_i);
            drive_idle();
            load_random(ex_isa_pkg::CSR_RW, 1);
            issued    = fu_data;
            csr_valid = 1'b1;
            #1;
            check_bit("flu_ready_o", 1'b1, flu_ready);
            check_bit("flu_valid_o", 1'b1, flu_valid);
            check_xlen("flu_result_o", issued.operand_a, flu_result);
            check_trans_id("flu_trans_id_o", issued.trans_id, flu_trans_id);
            hold = 1 + {$random(seed)} % 3;
            for (int i = 0; i <= hold; i++) begin
                @(negedge clk_i);
                drive_idle();
                // Last cycle of the hold carries the commit
                csr_commit = (i == hold);
                #1;
                check_bit("flu_ready_o", 1'b0, flu_ready);
                check_csr_addr("csr_addr_o", issued.operand_b[11:0], csr_addr);
            end
            @(negedge clk_i);
            drive_idle();
            wait_ready(4);
        end
    endtask

    task automatic stream_mults(input int count);
        ex_fu_pkg::wb_t exp_q [$];
        ex_fu_pkg::wb_t exp_wb;
        logic [63:0]    prod;
        for (int i = 0; i < count + NumMultStages + 1; i++) begin
            @(negedge clk_i);
            drive_idle();
            if (i < count) begin
                load_random(ex_isa_pkg::MUL, 2);
                prod            = {32'b0, fu_data.operand_a} * {32'b0, fu_data.operand_b};
                exp_wb.trans_id = fu_data.trans_id;
                exp_wb.result   = (fu_data.operation == ex_isa_pkg::MULHU) ?
                                  prod[63:32] : prod[31:0];
                exp_q.push_back(exp_wb);
                mult_valid = 1'b1;
            end
            #1;
            if (i >= NumMultStages && i < count + NumMultStages) begin
                exp_wb = exp_q.pop_front();
                check_bit("flu_valid_o", 1'b1, flu_valid);
                check_xlen("flu_result_o", exp_wb.result, flu_result);
                check_trans_id("flu_trans_id_o", exp_wb.trans_id, flu_trans_id);
            end else begin
                check_bit("flu_valid_o", 1'b0, flu_valid);
            end
        end
    endtask

    // Fill the CSR buffer, put two multiplies in flight, then flush
    task automatic flush_in_flight();
        @(negedge clk_i);
        drive_idle();
        load_random(ex_isa_pkg::CSR_RW, 1);
        csr_valid = 1'b1;
        @(negedge clk_i);
        drive_idle();
        load_random(ex_isa_pkg::MUL, 2);
        mult_valid = 1'b1;
        #1;
        check_bit("flu_ready_o", 1'b0, flu_ready);
        @(negedge clk_i);
        drive_idle();
        load_random(ex_isa_pkg::MULHU, 1);
        mult_valid = 1'b1;
        flush_i    = 1'b1;
        #1;
        check_bit("flu_valid_o", 1'b0, flu_valid);
        repeat (NumMultStages + 1) begin
            @(negedge clk_i);
            drive_idle();
            #1;
            check_bit("flu_valid_o", 1'b0, flu_valid);
            check_bit("flu_ready_o", 1'b1, flu_ready);
        end
    endtask

    initial begin
        seed          = 32'ha887;
        rst_ni        = 1'b0;
        fu_data       = '0;
        pc            = '0;
        is_compressed = 1'b0;
        drive_idle();
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        check_bit("flu_valid_o", 1'b0, flu_valid);
        check_bit("flu_ready_o", 1'b1, flu_ready);
        check_bit("resolve_branch_o", 1'b0, resolve_branch);

        issue_alu_ops(40, 1'b0);
        resolve_branches(60);
        issue_alu_ops(10, 1'b1);
        hold_csr(6);
        stream_mults(8);
        flush_in_flight();

        if (u_ex_stage.u_ex_stage_assert.fail_count != 0) begin
            report_failure("Concurrent assertions in ex_stage failed during the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- sim/ex_stage_assert.sv
/*
 * Protocol assertions for the execute stage, bound into ex_stage
 */

`timescale 1ns/10ps

module ex_stage_assert (
    input logic                       clk_i,
    input logic                       rst_ni,
    input logic                       flush_i,
    input logic                       branch_valid_i,
    input ex_fu_pkg::branch_predict_t branch_predict_i,
    input logic                       resolve_branch_i,
    input logic                       csr_valid_i,
    input logic                       csr_commit_i,
    input logic                       flu_ready_i,
    input ex_isa_pkg::csr_addr_t      csr_addr_i
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // Resolution needs a branch or a stray taken prediction
    resolve_has_cause: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        resolve_branch_i |-> (branch_valid_i || branch_predict_i.predict_taken)
    ) else begin
        fail_count++;
        $error("resolve_branch_o high without branch_valid_i or a taken prediction");
    end

    csr_issue_when_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> flu_ready_i
    ) else begin
        fail_count++;
        $error("csr_valid_i issued while the CSR buffer is full");
    end

    // Held address must not move until commit or flush
    csr_addr_held: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (!flu_ready_i && !csr_commit_i && !flush_i) |=> $stable(csr_addr_i)
    ) else begin
        fail_count++;
        $error("csr_addr_o changed while the CSR buffer is full");
    end

endmodule

bind ex_stage ex_stage_assert u_ex_stage_assert (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .branch_valid_i   (branch_valid_i),
    .branch_predict_i (branch_predict_i),
    .resolve_branch_i (resolve_branch_o),
    .csr_valid_i      (csr_valid_i),
    .csr_commit_i     (csr_commit_i),
    .flu_ready_i      (flu_ready_o),
    .csr_addr_i       (csr_addr_o)
);

//--- source/ex_stage.sv
/*
 * Fixed-latency execute stage: ALU, branch unit, CSR buffer and pipelined
 * multiplier behind one issue port and one write-back port
 */

`timescale 1ns/10ps

module ex_stage #(
    parameter int unsigned NumMultStages = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  ex_fu_pkg::fu_data_t        fu_data_i,
    input  ex_isa_pkg::xlen_t          pc_i,
    input  logic                       is_compressed_instr_i,
    input  logic                       alu_valid_i,
    input  logic                       branch_valid_i,
    input  logic                       csr_valid_i,
    input  logic                       mult_valid_i,
    input  ex_fu_pkg::branch_predict_t branch_predict_i,
    input  logic                       csr_commit_i,
    output ex_isa_pkg::xlen_t          flu_result_o,
    output ex_isa_pkg::trans_id_t      flu_trans_id_o,
    output logic                       flu_valid_o,
    output logic                       flu_ready_o,
    output ex_fu_pkg::bp_resolve_t     resolved_branch_o,
    output logic                       resolve_branch_o,
    output ex_isa_pkg::csr_addr_t      csr_addr_o
);

    ex_fu_pkg::fu_data_t alu_data;
    ex_fu_pkg::fu_data_t mult_data;
    ex_isa_pkg::xlen_t   alu_result;
    ex_isa_pkg::xlen_t   branch_result;
    ex_isa_pkg::xlen_t   csr_result;
    ex_fu_pkg::wb_t      mult_wb;
    logic                alu_branch_res;
    logic                csr_ready;
    logic                mult_valid;

    // ------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------
    // Silenced operands keep idle units from toggling
    assign alu_data  = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    alu u_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Any other unit valid lets a stray taken prediction be caught
    branch_unit u_branch_unit (
        .fu_data_i         (fu_data_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_instr_i),
        .fu_valid_i        (alu_valid_i | csr_valid_i | mult_valid_i),
        .branch_valid_i    (branch_valid_i),
        .branch_comp_res_i (alu_branch_res),
        .branch_predict_i  (branch_predict_i),
        .branch_result_o   (branch_result),
        .resolved_branch_o (resolved_branch_o),
        .resolve_branch_o  (resolve_branch_o)
    );

    csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    mult #(
        .NumMultStages (NumMultStages)
    ) u_mult (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .fu_data_i    (mult_data),
        .wb_o         (mult_wb),
        .mult_valid_o (mult_valid)
    );

    // ------------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    // Fixed priority ALU, CSR, multiplier with the link address as default
    always_comb begin
        flu_result_o   = branch_result;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_wb.result;
            flu_trans_id_o = mult_wb.trans_id;
        end
    end

endmodule

//--- source/mult.sv
/*
 * Pipelined unsigned multiplier with a fixed latency of NumMultStages.
 * Accepts one operation per cycle and tags each result with its trans_id
 */

`timescale 1ns/10ps

module mult #(
    parameter int unsigned NumMultStages = 2
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                mult_valid_i,
    input  ex_fu_pkg::fu_data_t fu_data_i,
    output ex_fu_pkg::wb_t      wb_o,
    output logic                mult_valid_o
);

    logic [2*ex_isa_pkg::XLEN-1:0] product;
    ex_fu_pkg::wb_t                wb_d;
    ex_fu_pkg::wb_t                stage_q [NumMultStages];
    logic [NumMultStages-1:0]      valid_q;

    assign product = fu_data_i.operand_a * fu_data_i.operand_b;

    // MULHU takes the upper half, everything else the lower
    assign wb_d.trans_id = fu_data_i.trans_id;
    assign wb_d.result   = (fu_data_i.operation == ex_isa_pkg::MULHU) ?
                           product[2*ex_isa_pkg::XLEN-1:ex_isa_pkg::XLEN] :
                           product[ex_isa_pkg::XLEN-1:0];

    // ------------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            for (int i = NumMultStages - 1; i > 0; i--) begin
                valid_q[i] <= valid_q[i-1];
            end
            valid_q[0] <= mult_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = NumMultStages - 1; i > 0; i--) begin
            stage_q[i] <= stage_q[i-1];
        end
        stage_q[0] <= wb_d;
    end

    assign wb_o         = stage_q[NumMultStages-1];
    assign mult_valid_o = valid_q[NumMultStages-1];

endmodule

//--- source/csr_buffer.sv
/*
 * Single-entry CSR buffer. Holds the CSR address until the instruction
 * commits and blocks further issue while it is occupied
 */

`timescale 1ns/10ps

module csr_buffer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  ex_fu_pkg::fu_data_t   fu_data_i,
    input  logic                  csr_valid_i,
    input  logic                  csr_commit_i,
    output logic                  csr_ready_o,
    output ex_isa_pkg::xlen_t     csr_result_o,
    output ex_isa_pkg::csr_addr_t csr_addr_o
);

    logic                  full_q;
    ex_isa_pkg::csr_addr_t addr_q;

    // Write data goes straight to write-back, the CSR file reads it at commit
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_ready_o  = ~full_q;
    assign csr_addr_o   = addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // Address lives in operand_b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i && !full_q) begin
            addr_q <= fu_data_i.operand_b[ex_isa_pkg::CSR_ADDR_BITS-1:0];
        end
    end

endmodule

//--- source/branch_unit.sv
/*
 * Resolves conditional branches and JALR against the fetch prediction.
 * Also catches a taken prediction on an instruction that is no branch
 */

`timescale 1ns/10ps

module branch_unit (
    input  ex_fu_pkg::fu_data_t        fu_data_i,
    input  ex_isa_pkg::xlen_t          pc_i,
    input  logic                       is_compressed_i,
    input  logic                       fu_valid_i,
    input  logic                       branch_valid_i,
    input  logic                       branch_comp_res_i,
    input  ex_fu_pkg::branch_predict_t branch_predict_i,
    output ex_isa_pkg::xlen_t          branch_result_o,
    output ex_fu_pkg::bp_resolve_t     resolved_branch_o,
    output logic                       resolve_branch_o
);

    ex_isa_pkg::xlen_t link_addr;
    ex_isa_pkg::xlen_t jalr_sum;
    ex_isa_pkg::xlen_t target;
    logic              taken;

    // Next sequential PC doubles as the link value
    assign link_addr = pc_i + (is_compressed_i ? ex_isa_pkg::xlen_t'(2) :
                                                 ex_isa_pkg::xlen_t'(4));
    assign jalr_sum  = fu_data_i.operand_a + fu_data_i.imm;

    assign branch_result_o = link_addr;

    // Outcome of the instruction on the port
    always_comb begin
        taken  = 1'b0;
        target = link_addr;
        if (fu_data_i.operation == ex_isa_pkg::JALR) begin
            taken  = 1'b1;
            target = {jalr_sum[ex_isa_pkg::XLEN-1:1], 1'b0};
        end else if (branch_comp_res_i) begin
            taken  = 1'b1;
            target = pc_i + fu_data_i.imm;
        end
    end

    // ------------------------------------------------------------------
    // Resolution
    // ------------------------------------------------------------------
    always_comb begin
        resolved_branch_o = '0;
        resolve_branch_o  = 1'b0;

        if (branch_valid_i) begin
            resolve_branch_o                 = 1'b1;
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.pc             = pc_i;
            resolved_branch_o.target_address = target;
            resolved_branch_o.is_taken       = taken;
            resolved_branch_o.is_mispredict  =
                (branch_predict_i.predict_taken != taken) ||
                (taken && (branch_predict_i.predict_address != target));
        end else if (fu_valid_i && branch_predict_i.predict_taken) begin
            // Taken prediction on a non-branch, so fall through to pc+2/4
            resolve_branch_o                 = 1'b1;
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.pc             = pc_i;
            resolved_branch_o.target_address = link_addr;
            resolved_branch_o.is_taken       = 1'b0;
            resolved_branch_o.is_mispredict  = 1'b1;
        end
    end

endmodule

//--- source/alu.sv
/*
 * Single-cycle ALU. Computes arithmetic, logic, shift and set-less-than
 * results and the comparison used by the branch unit
 */

`timescale 1ns/10ps

module alu (
    input  ex_fu_pkg::fu_data_t fu_data_i,
    output ex_isa_pkg::xlen_t   result_o,
    output logic                branch_res_o
);

    ex_isa_pkg::xlen_t           op_a;
    ex_isa_pkg::xlen_t           op_b;
    logic [4:0]                  shamt;
    logic [ex_isa_pkg::XLEN:0]   diff;
    logic                        less_signed;
    logic                        less_unsigned;
    logic                        is_equal;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    assign shamt = op_b[4:0];

    // One subtractor serves SUB and all compares; top bit is the borrow
    assign diff          = {1'b0, op_a} - {1'b0, op_b};
    assign less_unsigned = diff[ex_isa_pkg::XLEN];
    assign is_equal      = (op_a == op_b);

    // Differing signs decide directly, otherwise the sign of the difference
    assign less_signed = (op_a[ex_isa_pkg::XLEN-1] != op_b[ex_isa_pkg::XLEN-1]) ?
                         op_a[ex_isa_pkg::XLEN-1] : diff[ex_isa_pkg::XLEN-1];

    // ------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------
    always_comb begin
        case (fu_data_i.operation)
            ex_isa_pkg::ADD:  result_o = op_a + op_b;
            ex_isa_pkg::SUB:  result_o = diff[ex_isa_pkg::XLEN-1:0];
            ex_isa_pkg::XORL: result_o = op_a ^ op_b;
            ex_isa_pkg::ORL:  result_o = op_a | op_b;
            ex_isa_pkg::ANDL: result_o = op_a & op_b;
            ex_isa_pkg::SLL:  result_o = op_a << shamt;
            ex_isa_pkg::SRL:  result_o = op_a >> shamt;
            ex_isa_pkg::SRA:  result_o = ex_isa_pkg::xlen_t'($signed(op_a) >>> shamt);
            ex_isa_pkg::SLTS: result_o = ex_isa_pkg::xlen_t'(less_signed);
            ex_isa_pkg::SLTU: result_o = ex_isa_pkg::xlen_t'(less_unsigned);
            default:          result_o = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Branch comparison
    // ------------------------------------------------------------------
    always_comb begin
        case (fu_data_i.operation)
            ex_isa_pkg::EQ:  branch_res_o = is_equal;
            ex_isa_pkg::NE:  branch_res_o = ~is_equal;
            ex_isa_pkg::LTS: branch_res_o = less_signed;
            ex_isa_pkg::GES: branch_res_o = ~less_signed;
            ex_isa_pkg::LTU: branch_res_o = less_unsigned;
            ex_isa_pkg::GEU: branch_res_o = ~less_unsigned;
            default:         branch_res_o = 1'b0;
        endcase
    end

endmodule

//--- source/ex_fu_pkg.sv
/*
 * Structures exchanged between the issue logic, the fixed-latency
 * functional units and the branch predictor
 */

package ex_fu_pkg;

    // ------------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------------
    // One issued instruction, shared by all units on the issue port
    typedef struct packed {
        ex_isa_pkg::fu_op_e    operation;
        ex_isa_pkg::xlen_t     operand_a;
        ex_isa_pkg::xlen_t     operand_b;
        ex_isa_pkg::xlen_t     imm;
        ex_isa_pkg::trans_id_t trans_id;
    } fu_data_t;

    // Prediction made at fetch for this instruction
    typedef struct packed {
        logic              predict_taken;
        ex_isa_pkg::xlen_t predict_address;
    } branch_predict_t;

    // ------------------------------------------------------------------
    // Result side
    // ------------------------------------------------------------------
    // Branch resolution sent back to the predictor and the frontend
    typedef struct packed {
        logic              valid;
        ex_isa_pkg::xlen_t pc;
        ex_isa_pkg::xlen_t target_address;
        logic              is_mispredict;
        logic              is_taken;
    } bp_resolve_t;

    // Write-back of a pipelined unit
    typedef struct packed {
        ex_isa_pkg::trans_id_t trans_id;
        ex_isa_pkg::xlen_t     result;
    } wb_t;

endpackage

//--- source/ex_isa_pkg.sv
/*
 * ISA-level widths, base types and the operation encoding shared by the
 * execute stage and its functional units
 */

package ex_isa_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;

    // ------------------------------------------------------------------
    // Operation encoding
    // ------------------------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD,
        SUB,
        XORL,
        ORL,
        ANDL,
        SLL,
        SRL,
        SRA,
        SLTS,
        SLTU,
        // Branch comparisons and indirect jump
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        JALR,
        // CSR access
        CSR_RW,
        // Multiplier
        MUL,
        MULHU
    } fu_op_e;

endpackage
